// File: bench/kv_tb.sv
// directed testbench for kv_top, stops at the first mismatch
// model tracks entries loaded in offset order from zero
`timescale 1ns/1ns
`default_nettype none
`include "kv_macros.svh"

module kv_tb;

    localparam int MAX_CYCLES = 4000;

    logic clk;
    logic reset_i;
    logic debug_unlock;
    kv_pkg::kv_reg_req_t reg_req;
    kv_pkg::kv_reg_rsp_t reg_rsp;
    logic load_valid;
    logic load_ready;
    kv_pkg::kv_load_beat_t load_beat;
    logic load_done;
    logic load_err;
    logic [`KV_NUM_READ-1:0] req_valid;
    logic [`KV_NUM_READ-1:0] req_ready;
    logic [`KV_NUM_READ-1:0][`KV_ENTRY_W-1:0] req_entry;
    logic [`KV_NUM_READ-1:0] key_valid;
    logic [`KV_NUM_READ-1:0] key_ready;
    kv_pkg::kv_key_beat_t [`KV_NUM_READ-1:0] key_beat;
    logic [`KV_NUM_DWORDS-1:0][31:0] signing_key;
    int cycle_count = 0;

    // reference model of the vault
    logic [31:0] model_key [`KV_NUM_KEYS][`KV_NUM_DWORDS];
    int model_len [`KV_NUM_KEYS];
    logic [`KV_NUM_READ-1:0] model_dv [`KV_NUM_KEYS];
    logic model_lock_wr [`KV_NUM_KEYS];
    logic model_lock_use [`KV_NUM_KEYS];

    kv_top dut0 (
        .clk(clk),
        .reset_i(reset_i),
        .debug_unlock_i(debug_unlock),
        .reg_req_i(reg_req),
        .reg_rsp_o(reg_rsp),
        .load_valid_i(load_valid),
        .load_ready_o(load_ready),
        .load_beat_i(load_beat),
        .load_done_o(load_done),
        .load_err_o(load_err),
        .req_valid_i(req_valid),
        .req_ready_o(req_ready),
        .req_entry_i(req_entry),
        .key_valid_o(key_valid),
        .key_ready_i(key_ready),
        .key_beat_o(key_beat),
        .signing_key_o(signing_key)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $fatal(1, "run stopped on timeout");
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
            input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Fail %s expected %0h actual %0h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "run stopped on mismatch");
        end
    endtask

    // beat a reader should deliver at index idx, from the lock and permission rules
    function automatic kv_pkg::kv_key_beat_t expected_beat(input int r, input int e,
            input int idx);
        kv_pkg::kv_key_beat_t b;
        if (model_lock_use[e] || !model_dv[e][r]) begin
            b.data = '0;
            b.last = 1'b1;
            b.error = 1'b1;
        end else begin
            b.data = model_key[e][idx];
            b.last = idx == model_len[e] - 1;
            b.error = 1'b0;
        end
        return b;
    endfunction

    function automatic logic [31:0] status_word(input int e);
        logic [31:0] w;
        w = '0;
        w[0] = model_lock_wr[e];
        w[1] = model_lock_use[e];
        w[8 +: `KV_NUM_READ] = model_dv[e];
        w[12 +: `KV_DWORD_W] = (model_len[e] == 0) ? '0 : `KV_DWORD_W'(model_len[e] - 1);
        return w;
    endfunction

    task automatic reg_access(input string name, input logic wr, input int addr,
            input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
        check({name, " ack idle"}, 0, reg_rsp.ack);
        reg_req.valid = 1'b1;
        reg_req.write = wr;
        reg_req.addr = `KV_REG_ADDR_W'(addr);
        reg_req.wdata = wdata;
        @(negedge clk);
        check({name, " ack"}, 1, reg_rsp.ack);
        rdata = reg_rsp.rdata;
        err = reg_rsp.err;
        reg_req = '0;
        @(negedge clk);
        check({name, " ack single cycle"}, 0, reg_rsp.ack);
    endtask

    task automatic reg_write(input string name, input int addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic err;
        reg_access(name, 1'b1, addr, wdata, rdata, err);
        check({name, " write err"}, 0, err);
    endtask

    task automatic reg_read_check(input string name, input int addr,
            input logic [31:0] expected);
        logic [31:0] rdata;
        logic err;
        reg_access(name, 1'b0, addr, '0, rdata, err);
        check({name, " read err"}, 0, err);
        check({name, " read data"}, expected, rdata);
    endtask

    // streams one key with random data, a refused key leaves the model untouched
    task automatic load_key(input string name, input int entry, input int len,
            input logic [`KV_NUM_READ-1:0] dv);
        logic [31:0] data [`KV_NUM_DWORDS];
        logic exp_err;
        int wait_cycles;
        exp_err = model_lock_wr[entry] | model_lock_use[entry];
        for (int i = 0; i < len; i++) begin
            data[i] = $urandom;
            check({name, " load ready"}, 1, load_ready);
            load_valid = 1'b1;
            load_beat.entry = `KV_ENTRY_W'(entry);
            load_beat.offset = `KV_DWORD_W'(i);
            load_beat.data = data[i];
            load_beat.dest_valid = dv;
            load_beat.last = i == len - 1;
            @(negedge clk);
        end
        load_valid = 1'b0;
        wait_cycles = 0;
        while (!load_done) begin
            if (wait_cycles > 10) begin
                report_failure({name, ": load done pulse never arrived"});
            end
            @(negedge clk);
            wait_cycles++;
        end
        check({name, " load err"}, exp_err, load_err);
        @(negedge clk);
        check({name, " load done single cycle"}, 0, load_done);
        if (!exp_err) begin
            for (int i = 0; i < len; i++) begin
                model_key[entry][i] = data[i];
            end
            model_len[entry] = len;
            model_dv[entry] = dv;
        end
    endtask

    // requests an entry on reader r and checks every beat, stall adds random gaps
    task automatic read_key(input string name, input int r, input int entry, input bit stall);
        kv_pkg::kv_key_beat_t exp_beat;
        int idx;
        int idle;
        logic rdy;
        logic done;
        check({name, " req ready"}, 1, req_ready[r]);
        req_valid[r] = 1'b1;
        req_entry[r] = `KV_ENTRY_W'(entry);
        @(negedge clk);
        req_valid[r] = 1'b0;
        idx = 0;
        idle = 0;
        done = 1'b0;
        while (!done) begin
            check({name, " req ready during stream"}, 0, req_ready[r]);
            rdy = stall ? (($urandom % 2) == 1) : 1'b1;
            key_ready[r] = rdy;
            if (key_valid[r]) begin
                idle = 0;
                if (rdy) begin
                    exp_beat = expected_beat(r, entry, idx);
                    check({name, " key data"}, exp_beat.data, key_beat[r].data);
                    check({name, " key last"}, exp_beat.last, key_beat[r].last);
                    check({name, " key error"}, exp_beat.error, key_beat[r].error);
                    done = exp_beat.last;
                    idx++;
                end
            end else begin
                idle++;
                if (idle > 8) begin
                    report_failure({name, ": reader gave no key beat in time"});
                end
            end
            @(negedge clk);
        end
        key_ready[r] = 1'b0;
        check({name, " req ready after stream"}, 1, req_ready[r]);
    endtask

    task automatic check_signing(input string name);
        for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
            check({name, " signing key"}, model_key[`KV_SIGNING_ENTRY][d], signing_key[d]);
        end
    endtask

    task automatic apply_flush(input logic [31:0] pattern);
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            if (!model_lock_wr[e] && !model_lock_use[e]) begin
                for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
                    model_key[e][d] = pattern;
                end
            end
        end
    endtask

    task automatic test_store_read();
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            load_key("store_read", e, 1 + ($urandom % `KV_NUM_DWORDS), 2'b01);
        end
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            read_key("store_read r0", 0, e, 1'b0);
            read_key("store_read r1", 1, e, 1'b0);
        end
        check_signing("store_read");
    endtask

    task automatic test_locks();
        reg_write("locks set wr", 1, 32'h1);
        model_lock_wr[1] = 1'b1;
        load_key("locks reload", 1, `KV_NUM_DWORDS, 2'b11);
        read_key("locks old data", 0, 1, 1'b0);
        read_key("locks no permission", 1, 1, 1'b0);
        // a locked entry ignores the clear
        reg_write("locks clear", 1, 32'h4);
        read_key("locks after clear", 0, 1, 1'b0);
        reg_write("locks set use", 1, 32'h2);
        model_lock_use[1] = 1'b1;
        read_key("locks use", 0, 1, 1'b0);
        reg_read_check("locks readback", 1, status_word(1));
    endtask

    task automatic test_clear();
        reg_write("clear", 2, 32'h4);
        for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
            model_key[2][d] = '0;
        end
        model_len[2] = 0;
        model_dv[2] = '0;
        reg_read_check("clear readback", 2, status_word(2));
        read_key("clear r0", 0, 2, 1'b0);
        read_key("clear r1", 1, 2, 1'b0);
    endtask

    task automatic test_flush();
        reg_write("flush lock", 3, 32'h1);
        model_lock_wr[3] = 1'b1;
        reg_write("flush sel0", `KV_NUM_KEYS, 32'h1);
        apply_flush(`KV_DEBUG_VALUE_0);
        read_key("flush0 entry0", 0, 0, 1'b0);
        read_key("flush0 locked", 0, 3, 1'b0);
        read_key("flush0 signing", 0, `KV_SIGNING_ENTRY, 1'b0);
        check_signing("flush0");
        reg_write("flush sel1", `KV_NUM_KEYS, 32'h2);
        reg_read_check("flush sel readback", `KV_NUM_KEYS, 32'h2);
        debug_unlock = 1'b1;
        @(negedge clk);
        debug_unlock = 1'b0;
        apply_flush(`KV_DEBUG_VALUE_1);
        read_key("flush1 entry0", 0, 0, 1'b0);
        read_key("flush1 locked", 0, 3, 1'b0);
        check_signing("flush1");
    endtask

    task automatic test_backpressure();
        load_key("backpressure load4", 4, 1 + ($urandom % `KV_NUM_DWORDS), 2'b11);
        load_key("backpressure load5", 5, `KV_NUM_DWORDS, 2'b11);
        fork
            read_key("backpressure r0", 0, 4, 1'b1);
            read_key("backpressure r1", 1, 5, 1'b1);
        join
        fork
            read_key("backpressure r0 swap", 0, 5, 1'b1);
            read_key("backpressure r1 swap", 1, 4, 1'b1);
        join
    endtask

    task automatic test_reg_port();
        logic [31:0] rdata;
        logic err;
        reg_read_check("reg_port mapped", 0, status_word(0));
        reg_access("reg_port unmapped read", 1'b0, 9, '0, rdata, err);
        check("reg_port unmapped read err", 1, err);
        check("reg_port unmapped read data", 0, rdata);
        reg_access("reg_port unmapped write", 1'b1, 15, 32'hffffffff, rdata, err);
        check("reg_port unmapped write err", 1, err);
        check("reg_port unmapped write data", 0, rdata);
        @(negedge clk);
        check("reg_port no request", 0, reg_rsp.ack);
    endtask

    initial begin
        void'($urandom(32'hc6c5f285));
        clk = 1'b0;
        reset_i = 1'b1;
        debug_unlock = 1'b0;
        reg_req = '0;
        load_valid = 1'b0;
        load_beat = '0;
        req_valid = '0;
        req_entry = '0;
        key_ready = '0;
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
                model_key[e][d] = '0;
            end
            model_len[e] = 0;
            model_dv[e] = '0;
            model_lock_wr[e] = 1'b0;
            model_lock_use[e] = 1'b0;
        end
        repeat (8) @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);
        check("reset load done", 0, load_done);
        check("reset key valid", 0, key_valid);
        check("reset ack", 0, reg_rsp.ack);
        test_store_read();
        test_locks();
        test_clear();
        test_flush();
        test_backpressure();
        test_reg_port();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: common/kv_macros.svh
// vault sizes, flush patterns and the signing entry
// entry and offset widths must cover KV_NUM_KEYS and KV_NUM_DWORDS
`ifndef KV_MACROS_SVH
`define KV_MACROS_SVH

// storage geometry
`define KV_NUM_KEYS 8
`define KV_NUM_DWORDS 8
`define KV_ENTRY_W 3
`define KV_DWORD_W 3

// number of key reader clients, one dest_valid bit each
`define KV_NUM_READ 2

// patterns written into unlocked entries on a flush
`define KV_DEBUG_VALUE_0 32'ha5a5a5a5
`define KV_DEBUG_VALUE_1 32'h5a5a5a5a

// entry whose dwords drive the signing key output
`define KV_SIGNING_ENTRY 7

// register port, KEY_CTRL at 0..KV_NUM_KEYS-1, CLEAR_SECRETS at KV_NUM_KEYS
`define KV_REG_ADDR_W 4

`endif

// File: common/kv_pkg.sv
// types shared by the vault blocks and the testbench
// field widths follow kv_macros.svh
`default_nettype none
`include "kv_macros.svh"

package kv_pkg;

    // one beat of the key load stream
    typedef struct packed {
        logic [`KV_ENTRY_W-1:0] entry;
        logic [`KV_DWORD_W-1:0] offset;
        logic [31:0] data;
        logic [`KV_NUM_READ-1:0] dest_valid;
        logic last;
    } kv_load_beat_t;

    typedef struct packed {
        logic write_en;
        logic [`KV_ENTRY_W-1:0] write_entry;
        logic [`KV_DWORD_W-1:0] write_offset;
        logic [31:0] write_data;
        logic [`KV_NUM_READ-1:0] write_dest_valid;
    } kv_write_t;

    typedef struct packed {
        logic error;
    } kv_wr_resp_t;

    typedef struct packed {
        logic [`KV_ENTRY_W-1:0] read_entry;
        logic [`KV_DWORD_W-1:0] read_offset;
    } kv_read_t;

    typedef struct packed {
        logic [31:0] read_data;
        logic last;
        logic error;
    } kv_rd_resp_t;

    // output beat of a reader, error beats also carry last
    typedef struct packed {
        logic [31:0] data;
        logic last;
        logic error;
    } kv_key_beat_t;

    // clear is a single-cycle pulse
    typedef struct packed {
        logic lock_wr;
        logic lock_use;
        logic clear;
    } kv_entry_ctrl_t;

    typedef struct packed {
        logic [`KV_NUM_READ-1:0] dest_valid;
        logic [`KV_DWORD_W-1:0] last_dword;
    } kv_entry_status_t;

    typedef struct packed {
        logic valid;
        logic write;
        logic [`KV_REG_ADDR_W-1:0] addr;
        logic [31:0] wdata;
    } kv_reg_req_t;

    typedef struct packed {
        logic ack;
        logic [31:0] rdata;
        logic err;
    } kv_reg_rsp_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_HOLD
    } kv_reader_state_e;

endpackage

`default_nettype wire

// File: keyvault/kv_store.sv
// key storage with one write port and KV_NUM_READ combinational read ports
// a locked entry ignores writes, clears and flushes
`timescale 1ns/1ns
`default_nettype none
`include "kv_macros.svh"

module kv_store (
    input wire clk,
    input wire reset_i,
    input wire kv_pkg::kv_write_t kv_write_i,
    output kv_pkg::kv_wr_resp_t kv_wr_resp_o,
    input wire kv_pkg::kv_read_t [`KV_NUM_READ-1:0] kv_read_i,
    output kv_pkg::kv_rd_resp_t [`KV_NUM_READ-1:0] kv_rd_resp_o,
    input wire kv_pkg::kv_entry_ctrl_t [`KV_NUM_KEYS-1:0] entry_ctrl_i,
    input wire flush_i,
    input wire debug_sel_i,
    output kv_pkg::kv_entry_status_t [`KV_NUM_KEYS-1:0] entry_status_o,
    output logic [`KV_NUM_DWORDS-1:0][31:0] signing_key_o
);

    logic [`KV_NUM_KEYS-1:0][`KV_NUM_DWORDS-1:0][31:0] key_q;
    logic [`KV_NUM_KEYS-1:0][`KV_NUM_READ-1:0] dest_valid_q;
    logic [`KV_NUM_KEYS-1:0][`KV_DWORD_W-1:0] last_dword_q;
    logic [`KV_NUM_KEYS-1:0] entry_locked;
    logic [`KV_NUM_KEYS-1:0] entry_wr_hit;
    logic [31:0] debug_value;

    assign debug_value = debug_sel_i ? `KV_DEBUG_VALUE_1 : `KV_DEBUG_VALUE_0;

    // per-entry lock state and write address match
    always_comb begin
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            entry_locked[e] = entry_ctrl_i[e].lock_wr | entry_ctrl_i[e].lock_use;
            entry_wr_hit[e] = kv_write_i.write_en
                & (kv_write_i.write_entry == `KV_ENTRY_W'(e));
        end
    end

    // refused write, reported back in the same cycle
    assign kv_wr_resp_o.error = kv_write_i.write_en & entry_locked[kv_write_i.write_entry];

    // flush wins over clear, clear wins over a write to the same entry
    always_ff @(posedge clk) begin
        if (reset_i) begin
            key_q <= '0;
            dest_valid_q <= '0;
            last_dword_q <= '0;
        end else begin
            for (int e = 0; e < `KV_NUM_KEYS; e++) begin
                if (!entry_locked[e]) begin
                    if (flush_i) begin
                        // permissions survive a flush, only the data is replaced
                        key_q[e] <= {`KV_NUM_DWORDS{debug_value}};
                    end else if (entry_ctrl_i[e].clear) begin
                        key_q[e] <= '0;
                        dest_valid_q[e] <= '0;
                        last_dword_q[e] <= '0;
                    end else if (entry_wr_hit[e]) begin
                        key_q[e][kv_write_i.write_offset] <= kv_write_i.write_data;
                        dest_valid_q[e] <= kv_write_i.write_dest_valid;
                        // the final beat leaves its offset as the last dword
                        last_dword_q[e] <= kv_write_i.write_offset;
                    end
                end
            end
        end
    end

    // read ports, index r is the reader's bit in dest_valid
    for (genvar r = 0; r < `KV_NUM_READ; r++) begin : g_read_port
        logic [`KV_ENTRY_W-1:0] rd_entry;
        logic [`KV_DWORD_W-1:0] rd_offset;
        logic rd_error;

        assign rd_entry = kv_read_i[r].read_entry;
        assign rd_offset = kv_read_i[r].read_offset;

        // no data leaves for a use-locked entry or a reader without permission
        assign rd_error = entry_ctrl_i[rd_entry].lock_use | ~dest_valid_q[rd_entry][r];

        assign kv_rd_resp_o[r].error = rd_error;
        assign kv_rd_resp_o[r].read_data = rd_error ? 32'h0 : key_q[rd_entry][rd_offset];
        assign kv_rd_resp_o[r].last = rd_offset == last_dword_q[rd_entry];
    end

    always_comb begin
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            entry_status_o[e].dest_valid = dest_valid_q[e];
            entry_status_o[e].last_dword = last_dword_q[e];
        end
    end

    assign signing_key_o = key_q[`KV_SIGNING_ENTRY];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the key vault testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module kv_tb \
    --Mdir obj_dir -o kv_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/kv_tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
exit 0

// File: source/kv_ctrl_regs.sv
// firmware registers, ack and rdata one cycle after a valid request
// locks are sticky until reset, clear and flush are write-one pulses
`timescale 1ns/1ns
`default_nettype none
`include "kv_macros.svh"

module kv_ctrl_regs (
    input wire clk,
    input wire reset_i,
    input wire debug_unlock_i,
    input wire kv_pkg::kv_reg_req_t reg_req_i,
    output kv_pkg::kv_reg_rsp_t reg_rsp_o,
    input wire kv_pkg::kv_entry_status_t [`KV_NUM_KEYS-1:0] entry_status_i,
    output kv_pkg::kv_entry_ctrl_t [`KV_NUM_KEYS-1:0] entry_ctrl_o,
    output logic flush_o,
    output logic debug_sel_o
);

    logic [`KV_NUM_KEYS-1:0] lock_wr_q;
    logic [`KV_NUM_KEYS-1:0] lock_use_q;
    logic [`KV_NUM_KEYS-1:0] clear_q;
    logic flush_q;
    logic sel_q;
    logic [`KV_ENTRY_W-1:0] key_idx;
    logic key_hit;
    logic secrets_hit;
    logic wr_en;
    logic [31:0] rdata_d;
    kv_pkg::kv_reg_rsp_t rsp_q;

    // address decode
    assign key_idx = reg_req_i.addr[`KV_ENTRY_W-1:0];
    assign key_hit = reg_req_i.addr < `KV_REG_ADDR_W'(`KV_NUM_KEYS);
    assign secrets_hit = reg_req_i.addr == `KV_REG_ADDR_W'(`KV_NUM_KEYS);
    assign wr_en = reg_req_i.valid & reg_req_i.write;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            lock_wr_q <= '0;
            lock_use_q <= '0;
            clear_q <= '0;
            flush_q <= 1'b0;
            sel_q <= 1'b0;
        end else begin
            clear_q <= '0;
            flush_q <= 1'b0;
            if (wr_en && key_hit) begin
                // locks can only be set here
                lock_wr_q[key_idx] <= lock_wr_q[key_idx] | reg_req_i.wdata[0];
                lock_use_q[key_idx] <= lock_use_q[key_idx] | reg_req_i.wdata[1];
                clear_q[key_idx] <= reg_req_i.wdata[2];
            end
            if (wr_en && secrets_hit) begin
                flush_q <= reg_req_i.wdata[0];
                sel_q <= reg_req_i.wdata[1];
            end
        end
    end

    // readback, pulse bits read as zero
    always_comb begin
        rdata_d = '0;
        if (key_hit) begin
            rdata_d[0] = lock_wr_q[key_idx];
            rdata_d[1] = lock_use_q[key_idx];
            rdata_d[8 +: `KV_NUM_READ] = entry_status_i[key_idx].dest_valid;
            rdata_d[12 +: `KV_DWORD_W] = entry_status_i[key_idx].last_dword;
        end else if (secrets_hit) begin
            rdata_d[1] = sel_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rsp_q <= '0;
        end else begin
            rsp_q.ack <= reg_req_i.valid;
            rsp_q.err <= reg_req_i.valid & ~(key_hit | secrets_hit);
            rsp_q.rdata <= (reg_req_i.valid && !reg_req_i.write) ? rdata_d : '0;
        end
    end

    assign reg_rsp_o = rsp_q;

    always_comb begin
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            entry_ctrl_o[e].lock_wr = lock_wr_q[e];
            entry_ctrl_o[e].lock_use = lock_use_q[e];
            entry_ctrl_o[e].clear = clear_q[e];
        end
    end

    // debug unlock flushes in the same cycle it is seen
    assign flush_o = flush_q | debug_unlock_i;
    assign debug_sel_o = sel_q;

endmodule

`default_nettype wire

// File: source/kv_key_loader.sv
// load stream to vault writes, one write per accepted beat, no back-pressure
// done and err pulse one cycle after the write of the last beat
`timescale 1ns/1ns
`default_nettype none

module kv_key_loader (
    input wire clk,
    input wire reset_i,
    input wire load_valid_i,
    output logic load_ready_o,
    input wire kv_pkg::kv_load_beat_t load_beat_i,
    output kv_pkg::kv_write_t kv_write_o,
    input wire kv_pkg::kv_wr_resp_t kv_wr_resp_i,
    output logic load_done_o,
    output logic load_err_o
);

    logic ready_q;
    logic load_accept;
    logic write_en_q;
    logic key_end;
    logic err_acc_q;
    logic done_q;
    logic err_q;
    kv_pkg::kv_load_beat_t beat_q;

    assign load_accept = load_valid_i & ready_q;

    // write of the final beat of a key
    assign key_end = write_en_q & beat_q.last;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ready_q <= 1'b0;
            write_en_q <= 1'b0;
            err_acc_q <= 1'b0;
            done_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
            write_en_q <= load_accept;
            done_q <= key_end;
            err_q <= key_end & (err_acc_q | kv_wr_resp_i.error);
            // sticky over one key, dropped once it has been reported
            err_acc_q <= key_end ? 1'b0 : (err_acc_q | kv_wr_resp_i.error);
        end
    end

    always_ff @(posedge clk) begin
        if (load_accept) begin
            beat_q <= load_beat_i;
        end
    end

    always_comb begin
        kv_write_o.write_en = write_en_q;
        kv_write_o.write_entry = beat_q.entry;
        kv_write_o.write_offset = beat_q.offset;
        kv_write_o.write_data = beat_q.data;
        kv_write_o.write_dest_valid = beat_q.dest_valid;
    end

    assign load_ready_o = ready_q;
    assign load_done_o = done_q;
    assign load_err_o = err_q;

endmodule

`default_nettype wire

// File: source/kv_key_reader.sv
// streams one entry from offset zero until a last or error beat
// READER_ID must be below KV_NUM_READ and match the store port it is wired to
`timescale 1ns/1ns
`default_nettype none
`include "kv_macros.svh"

module kv_key_reader #(
    parameter int READER_ID = 0
) (
    input wire clk,
    input wire reset_i,
    input wire req_valid_i,
    output logic req_ready_o,
    input wire [`KV_ENTRY_W-1:0] req_entry_i,
    output kv_pkg::kv_read_t kv_read_o,
    input wire kv_pkg::kv_rd_resp_t kv_rd_resp_i,
    output logic key_valid_o,
    input wire key_ready_i,
    output kv_pkg::kv_key_beat_t key_beat_o
);

    kv_pkg::kv_reader_state_e state_q;
    logic [`KV_ENTRY_W-1:0] entry_q;
    logic [`KV_DWORD_W-1:0] offset_q;
    kv_pkg::kv_key_beat_t beat_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= kv_pkg::RD_IDLE;
        end else begin
            case (state_q)
                kv_pkg::RD_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= kv_pkg::RD_FETCH;
                    end
                end
                kv_pkg::RD_FETCH: state_q <= kv_pkg::RD_HOLD;
                kv_pkg::RD_HOLD: begin
                    if (key_ready_i) begin
                        state_q <= beat_q.last ? kv_pkg::RD_IDLE : kv_pkg::RD_FETCH;
                    end
                end
                default: state_q <= kv_pkg::RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == kv_pkg::RD_IDLE && req_valid_i) begin
            entry_q <= req_entry_i;
            offset_q <= '0;
        end
        if (state_q == kv_pkg::RD_HOLD && key_ready_i) begin
            offset_q <= offset_q + 1'b1;
        end
        if (state_q == kv_pkg::RD_FETCH) begin
            beat_q.data <= kv_rd_resp_i.read_data;
            // an error always ends the stream
            beat_q.last <= kv_rd_resp_i.last | kv_rd_resp_i.error;
            beat_q.error <= kv_rd_resp_i.error;
        end
    end

    assign kv_read_o.read_entry = entry_q;
    assign kv_read_o.read_offset = offset_q;

    assign req_ready_o = state_q == kv_pkg::RD_IDLE;
    assign key_valid_o = state_q == kv_pkg::RD_HOLD;
    assign key_beat_o = beat_q;

endmodule

`default_nettype wire

// File: source/kv_top.sv
// key vault top, one loader and KV_NUM_READ readers around the store
// single synchronous reset for all blocks
`timescale 1ns/1ns
`default_nettype none
`include "kv_macros.svh"

module kv_top (
    input wire clk,
    input wire reset_i,
    input wire debug_unlock_i,
    input wire kv_pkg::kv_reg_req_t reg_req_i,
    output kv_pkg::kv_reg_rsp_t reg_rsp_o,
    input wire load_valid_i,
    output logic load_ready_o,
    input wire kv_pkg::kv_load_beat_t load_beat_i,
    output logic load_done_o,
    output logic load_err_o,
    input wire [`KV_NUM_READ-1:0] req_valid_i,
    output logic [`KV_NUM_READ-1:0] req_ready_o,
    input wire [`KV_NUM_READ-1:0][`KV_ENTRY_W-1:0] req_entry_i,
    output logic [`KV_NUM_READ-1:0] key_valid_o,
    input wire [`KV_NUM_READ-1:0] key_ready_i,
    output kv_pkg::kv_key_beat_t [`KV_NUM_READ-1:0] key_beat_o,
    output logic [`KV_NUM_DWORDS-1:0][31:0] signing_key_o
);

    kv_pkg::kv_entry_ctrl_t [`KV_NUM_KEYS-1:0] entry_ctrl;
    kv_pkg::kv_entry_status_t [`KV_NUM_KEYS-1:0] entry_status;
    kv_pkg::kv_write_t kv_write;
    kv_pkg::kv_wr_resp_t kv_wr_resp;
    kv_pkg::kv_read_t [`KV_NUM_READ-1:0] kv_read;
    kv_pkg::kv_rd_resp_t [`KV_NUM_READ-1:0] kv_rd_resp;
    logic flush;
    logic debug_sel;

    kv_ctrl_regs u_ctrl_regs (
        .clk(clk),
        .reset_i(reset_i),
        .debug_unlock_i(debug_unlock_i),
        .reg_req_i(reg_req_i),
        .reg_rsp_o(reg_rsp_o),
        .entry_status_i(entry_status),
        .entry_ctrl_o(entry_ctrl),
        .flush_o(flush),
        .debug_sel_o(debug_sel)
    );

    kv_store u_store (
        .clk(clk),
        .reset_i(reset_i),
        .kv_write_i(kv_write),
        .kv_wr_resp_o(kv_wr_resp),
        .kv_read_i(kv_read),
        .kv_rd_resp_o(kv_rd_resp),
        .entry_ctrl_i(entry_ctrl),
        .flush_i(flush),
        .debug_sel_i(debug_sel),
        .entry_status_o(entry_status),
        .signing_key_o(signing_key_o)
    );

    kv_key_loader u_key_loader (
        .clk(clk),
        .reset_i(reset_i),
        .load_valid_i(load_valid_i),
        .load_ready_o(load_ready_o),
        .load_beat_i(load_beat_i),
        .kv_write_o(kv_write),
        .kv_wr_resp_i(kv_wr_resp),
        .load_done_o(load_done_o),
        .load_err_o(load_err_o)
    );

    // reader r sits on store read port r
    for (genvar r = 0; r < `KV_NUM_READ; r++) begin : g_reader
        kv_key_reader #(
            .READER_ID(r)
        ) u_key_reader (
            .clk(clk),
            .reset_i(reset_i),
            .req_valid_i(req_valid_i[r]),
            .req_ready_o(req_ready_o[r]),
            .req_entry_i(req_entry_i[r]),
            .kv_read_o(kv_read[r]),
            .kv_rd_resp_i(kv_rd_resp[r]),
            .key_valid_o(key_valid_o[r]),
            .key_ready_i(key_ready_i[r]),
            .key_beat_o(key_beat_o[r])
        );
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/kv_pkg.sv
source/kv_ctrl_regs.sv
keyvault/kv_store.sv
source/kv_key_loader.sv
source/kv_key_reader.sv
source/kv_top.sv
bench/kv_tb.sv
